/* src/u2_ctrl_cfg.svh */
////////////////////////////////////////////////////////////////////////////
// Control-plane address map
// Slave decode field, settings addresses and readback size
////////////////////////////////////////////////////////////////////////////

`ifndef U2_CTRL_CFG_SVH
`define U2_CTRL_CFG_SVH

// Slave select is adr[7:6]
`define U2_DEC_LSB         6
`define U2_DEC_W           2

// Slave numbers, value 3 is left unmapped
`define U2_SLV_SETTINGS    0
`define U2_SLV_PIC         1
`define U2_SLV_READBACK    2

// Settings word addresses
`define U2_SR_CLK          0
`define U2_SR_SER          1
`define U2_SR_ADC          2
`define U2_SR_LED          3
`define U2_SR_PHY          4
`define U2_SR_LED_SRC      8

// One-time count here, periodic period in the next word
`define U2_SR_SIMTIMER     12

// Words in the status readback mux
`define U2_RB_WORDS        16

`endif

/* src/u2_ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Control-plane types
// Host bus, settings bus, interrupt vector and board control lines
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package u2_ctrl_pkg;

   typedef logic [15:0] bus_adr_t;
   typedef logic [31:0] bus_dat_t;
   typedef logic [7:0]  set_adr_t;
   typedef logic [7:0]  irq_vec_t;
   typedef logic [7:0]  led_t;

   // Single-word request, one strobe per access
   typedef struct packed {
      logic     stb;
      logic     we;
      bus_adr_t adr;
      bus_dat_t dat;
   } bus_req_t;

   typedef struct packed {
      logic     ack;
      logic     err;
      bus_dat_t dat;
   } bus_rsp_t;

   typedef struct packed {
      logic     stb;
      set_adr_t addr;
      bus_dat_t data;
   } set_bus_t;

   // Control lines to clock gen, SERDES, ADCs and PHY
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_resetn;
   } board_ctrl_t;

   // Index of highest set bit, all ones when none is set
   function automatic bus_dat_t prio_index(input logic [15:0] vec);
      bus_dat_t idx;
      idx = '1;
      for (int i = 0; i < 16; i++) begin
         if (vec[i]) begin
            idx = bus_dat_t'(i);
         end
      end
      return idx;
   endfunction

endpackage

`default_nettype wire

/* src/bus_decoder.sv */
////////////////////////////////////////////////////////////////////////////
// Single-master address decoder
// Steers each strobe to one slave and flags unmapped accesses
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "u2_ctrl_cfg.svh"

module bus_decoder (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  u2_ctrl_pkg::bus_req_t host_req_i,
   output u2_ctrl_pkg::bus_rsp_t host_rsp_o,
   output u2_ctrl_pkg::bus_req_t set_req_o,
   output u2_ctrl_pkg::bus_req_t pic_req_o,
   output u2_ctrl_pkg::bus_req_t rb_req_o,
   input  u2_ctrl_pkg::bus_rsp_t set_rsp_i,
   input  u2_ctrl_pkg::bus_rsp_t pic_rsp_i,
   input  u2_ctrl_pkg::bus_rsp_t rb_rsp_i
);
   import u2_ctrl_pkg::*;

   logic [`U2_DEC_W-1:0] slv_sel;
   logic                 unmapped;
   logic                 err_q;
   bus_dat_t             set_dat;
   bus_dat_t             pic_dat;
   bus_dat_t             rb_dat;

   assign slv_sel  = host_req_i.adr[`U2_DEC_LSB +: `U2_DEC_W];
   assign unmapped = host_req_i.stb &&
                     !(slv_sel inside {`U2_SLV_SETTINGS, `U2_SLV_PIC, `U2_SLV_READBACK});

   // Same request to all slaves, only the selected one sees stb
   always_comb begin
      set_req_o     = host_req_i;
      pic_req_o     = host_req_i;
      rb_req_o      = host_req_i;
      set_req_o.stb = host_req_i.stb && (slv_sel == `U2_SLV_SETTINGS);
      pic_req_o.stb = host_req_i.stb && (slv_sel == `U2_SLV_PIC);
      rb_req_o.stb  = host_req_i.stb && (slv_sel == `U2_SLV_READBACK);
   end

   // Unmapped access answers with err one cycle later
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= unmapped;
      end
   end

   // Data only from the slave that acks
   assign set_dat = set_rsp_i.ack ? set_rsp_i.dat : '0;
   assign pic_dat = pic_rsp_i.ack ? pic_rsp_i.dat : '0;
   assign rb_dat  = rb_rsp_i.ack ? rb_rsp_i.dat : '0;

   always_comb begin
      host_rsp_o.ack = set_rsp_i.ack | pic_rsp_i.ack | rb_rsp_i.ack | err_q;
      host_rsp_o.err = set_rsp_i.err | pic_rsp_i.err | rb_rsp_i.err | err_q;
      host_rsp_o.dat = set_dat | pic_dat | rb_dat;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Protocol checks

   assert property (@(posedge dsp_clk) disable iff (wb_rst)
      $onehot0({set_rsp_i.ack, pic_rsp_i.ack, rb_rsp_i.ack}));

   // Every access gets an answer on the next cycle
   assert property (@(posedge dsp_clk) disable iff (wb_rst)
      host_req_i.stb |=> (host_rsp_o.ack || host_rsp_o.err));

endmodule

`default_nettype wire

/* src/settings_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Settings slave
// Board control registers, LED source mux and the settings strobe
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "u2_ctrl_cfg.svh"

module settings_regs (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  u2_ctrl_pkg::bus_req_t    slv_req_i,
   output u2_ctrl_pkg::bus_rsp_t    slv_rsp_o,
   input  logic                     clk_status_i,
   input  logic                     serdes_link_up_i,
   output u2_ctrl_pkg::set_bus_t    set_bus_o,
   output u2_ctrl_pkg::board_ctrl_t board_o,
   output u2_ctrl_pkg::led_t        leds_o
);
   import u2_ctrl_pkg::*;

   set_adr_t   wr_adr;
   logic       wr_stb;
   logic [4:0] clk_reg;
   logic [3:0] ser_reg;
   logic [3:0] adc_reg;
   logic       phy_rst;
   led_t       led_sw;
   led_t       led_src;
   led_t       led_hw;
   logic       ack_q;
   logic       set_stb_q;
   set_adr_t   set_adr_q;
   bus_dat_t   set_dat_q;

   // Word offset is the settings address
   assign wr_adr = set_adr_t'(slv_req_i.adr[5:2]);
   assign wr_stb = slv_req_i.stb && slv_req_i.we;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clk_reg <= '0;
         ser_reg <= '0;
         adc_reg <= '0;
         phy_rst <= 1'b0;
         led_sw  <= '0;
         led_src <= '0;
      end else if (wr_stb) begin
         case (wr_adr)
            `U2_SR_CLK:     clk_reg <= slv_req_i.dat[4:0];
            `U2_SR_SER:     ser_reg <= slv_req_i.dat[3:0];
            `U2_SR_ADC:     adc_reg <= slv_req_i.dat[3:0];
            `U2_SR_LED:     led_sw  <= slv_req_i.dat[7:0];
            `U2_SR_PHY:     phy_rst <= slv_req_i.dat[0];
            `U2_SR_LED_SRC: led_src <= slv_req_i.dat[7:0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_q     <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         ack_q     <= slv_req_i.stb;
         set_stb_q <= wr_stb;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (wr_stb) begin
         set_adr_q <= wr_adr;
         set_dat_q <= slv_req_i.dat;
      end
   end

   // Write-only slave
   always_comb begin
      slv_rsp_o.ack = ack_q;
      slv_rsp_o.err = 1'b0;
      slv_rsp_o.dat = '0;
   end

   always_comb begin
      set_bus_o.stb  = set_stb_q;
      set_bus_o.addr = set_adr_q;
      set_bus_o.data = set_dat_q;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Board lines

   always_comb begin
      board_o.clock_ready = clk_reg[4];
      board_o.clk_en      = clk_reg[3:2];
      board_o.clk_sel     = clk_reg[1:0];
      board_o.ser_enable  = ser_reg[3];
      board_o.ser_prbsen  = ser_reg[2];
      board_o.ser_loopen  = ser_reg[1];
      board_o.ser_rx_en   = ser_reg[0];
      board_o.adc_oe_a    = adc_reg[3];
      board_o.adc_on_a    = adc_reg[2];
      board_o.adc_oe_b    = adc_reg[1];
      board_o.adc_on_b    = adc_reg[0];
      board_o.phy_resetn  = ~phy_rst;
   end

   // Source bit 1 picks hardware status, 0 picks software value
   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   assert property (@(posedge dsp_clk) disable iff (wb_rst)
      set_bus_o.stb |-> ($past(wr_stb) && set_bus_o.data == $past(slv_req_i.dat)));

endmodule

`default_nettype wire

/* src/sys_timer.sv */
////////////////////////////////////////////////////////////////////////////
// One-time and periodic interrupt timer, loaded over the settings bus
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "u2_ctrl_cfg.svh"

module sys_timer (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  u2_ctrl_pkg::set_bus_t set_bus_i,
   output logic                  onetime_int_o,
   output logic                  periodic_int_o
);
   import u2_ctrl_pkg::*;

   logic     ld_onetime;
   logic     ld_period;
   bus_dat_t onetime_cnt;
   bus_dat_t period_q;
   bus_dat_t period_cnt;

   assign ld_onetime = set_bus_i.stb && (set_bus_i.addr == `U2_SR_SIMTIMER);
   assign ld_period  = set_bus_i.stb && (set_bus_i.addr == `U2_SR_SIMTIMER + 1);

   // Count of 0 cancels, otherwise fires N cycles after the load
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         onetime_cnt <= '0;
      end else if (ld_onetime) begin
         onetime_cnt <= set_bus_i.data;
      end else if (onetime_cnt != '0) begin
         onetime_cnt <= onetime_cnt - 1'b1;
      end
   end

   // Reload from the period register on terminal count
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         period_q   <= '0;
         period_cnt <= '0;
      end else if (ld_period) begin
         period_q   <= set_bus_i.data;
         period_cnt <= set_bus_i.data;
      end else if (period_q != '0) begin
         period_cnt <= (period_cnt <= 1) ? period_q : period_cnt - 1'b1;
      end
   end

   assign onetime_int_o  = (onetime_cnt == 1);
   assign periodic_int_o = (period_cnt == 1) && (period_q != '0);

endmodule

`default_nettype wire

/* src/int_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Interrupt controller
// Mask, sticky pending with write-one-to-clear, highest pending index
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module int_ctrl (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  u2_ctrl_pkg::bus_req_t slv_req_i,
   output u2_ctrl_pkg::bus_rsp_t slv_rsp_o,
   input  u2_ctrl_pkg::irq_vec_t irq_vec_i,
   output logic                  int_o
);
   import u2_ctrl_pkg::*;

   logic [3:0] word;
   logic       wr_stb;
   logic       rd_stb;
   irq_vec_t   mask_q;
   irq_vec_t   pend_q;
   irq_vec_t   pend_clr;
   irq_vec_t   active;
   bus_dat_t   rd_dat;
   bus_dat_t   dat_q;
   logic       ack_q;
   logic       int_q;

   assign word   = slv_req_i.adr[5:2];
   assign wr_stb = slv_req_i.stb && slv_req_i.we;
   assign rd_stb = slv_req_i.stb && !slv_req_i.we;

   // W1C on word 1
   assign pend_clr = (wr_stb && word == 4'd1) ? slv_req_i.dat[7:0] : '0;
   assign active   = pend_q & mask_q;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         mask_q <= '0;
         pend_q <= '0;
         int_q  <= 1'b0;
         ack_q  <= 1'b0;
      end else begin
         if (wr_stb && word == 4'd0) begin
            mask_q <= slv_req_i.dat[7:0];
         end
         // A live irq wins over a clear in the same cycle
         pend_q <= (pend_q & ~pend_clr) | irq_vec_i;
         int_q  <= |active;
         ack_q  <= slv_req_i.stb;
      end
   end

   always_comb begin
      case (word)
         4'd0:    rd_dat = {24'b0, mask_q};
         4'd1:    rd_dat = {24'b0, pend_q};
         4'd2:    rd_dat = prio_index({8'b0, active});
         default: rd_dat = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      dat_q <= rd_stb ? rd_dat : '0;
   end

   always_comb begin
      slv_rsp_o.ack = ack_q;
      slv_rsp_o.err = 1'b0;
      slv_rsp_o.dat = dat_q;
   end

   assign int_o = int_q;

endmodule

`default_nettype wire

/* src/status_readback.sv */
////////////////////////////////////////////////////////////////////////////
// Status readback slave
// Cycle counter, board status words and status priority encoder
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "u2_ctrl_cfg.svh"

module status_readback (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  u2_ctrl_pkg::bus_req_t slv_req_i,
   output u2_ctrl_pkg::bus_rsp_t slv_rsp_o,
   input  u2_ctrl_pkg::bus_dat_t status_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   input  u2_ctrl_pkg::irq_vec_t irq_vec_i
);
   import u2_ctrl_pkg::*;

   bus_dat_t cycle_cnt;
   bus_dat_t rb_word [`U2_RB_WORDS];
   bus_dat_t dat_q;
   logic     ack_q;

   // Free-running since reset
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + 1'b1;
      end
   end

   always_comb begin
      for (int i = 0; i < `U2_RB_WORDS; i++) begin
         rb_word[i] = '0;
      end
      rb_word[0] = cycle_cnt;
      rb_word[1] = {sim_mode_i, 27'b0, clock_divider_i};
      rb_word[2] = status_i;
      rb_word[3] = prio_index(status_i[15:0]);
      rb_word[4] = {24'b0, irq_vec_i};
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= slv_req_i.stb;
      end
   end

   // Writes get an ack and zero data
   always_ff @(posedge dsp_clk) begin
      dat_q <= (slv_req_i.stb && !slv_req_i.we) ? rb_word[slv_req_i.adr[5:2]] : '0;
   end

   always_comb begin
      slv_rsp_o.ack = ack_q;
      slv_rsp_o.err = 1'b0;
      slv_rsp_o.dat = dat_q;
   end

endmodule

`default_nettype wire

/* src/u2_ctrl_top.sv */
////////////////////////////////////////////////////////////////////////////
// Control-plane core
// Host bus decoder with settings, interrupt and readback slaves
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module u2_ctrl_top (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  u2_ctrl_pkg::bus_req_t    host_req_i,
   output u2_ctrl_pkg::bus_rsp_t    host_rsp_o,
   input  logic                     clk_status_i,
   input  logic                     serdes_link_up_i,
   input  logic                     phy_intn_i,
   input  logic [2:0]               ext_irq_i,
   input  u2_ctrl_pkg::bus_dat_t    status_i,
   input  logic                     sim_mode_i,
   input  logic [3:0]               clock_divider_i,
   output u2_ctrl_pkg::board_ctrl_t board_o,
   output u2_ctrl_pkg::led_t        leds_o,
   output logic                     int_o
);
   import u2_ctrl_pkg::*;

   bus_req_t set_req;
   bus_req_t pic_req;
   bus_req_t rb_req;
   bus_rsp_t set_rsp;
   bus_rsp_t pic_rsp;
   bus_rsp_t rb_rsp;
   set_bus_t set_bus;
   logic     onetime_int;
   logic     periodic_int;
   irq_vec_t irq_vec;

   // PHY interrupt is active low on the board
   assign irq_vec = {ext_irq_i, serdes_link_up_i, clk_status_i, ~phy_intn_i,
                     periodic_int, onetime_int};

   ////////////////////////////////////////////////////////////////////////////
   // Bus fabric

   bus_decoder u_decoder (
      .dsp_clk    (dsp_clk),
      .wb_rst     (wb_rst),
      .host_req_i (host_req_i),
      .host_rsp_o (host_rsp_o),
      .set_req_o  (set_req),
      .pic_req_o  (pic_req),
      .rb_req_o   (rb_req),
      .set_rsp_i  (set_rsp),
      .pic_rsp_i  (pic_rsp),
      .rb_rsp_i   (rb_rsp)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Slaves

   settings_regs u_settings (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .slv_req_i        (set_req),
      .slv_rsp_o        (set_rsp),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .set_bus_o        (set_bus),
      .board_o          (board_o),
      .leds_o           (leds_o)
   );

   sys_timer u_timer (
      .dsp_clk        (dsp_clk),
      .wb_rst         (wb_rst),
      .set_bus_i      (set_bus),
      .onetime_int_o  (onetime_int),
      .periodic_int_o (periodic_int)
   );

   int_ctrl u_pic (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .slv_req_i (pic_req),
      .slv_rsp_o (pic_rsp),
      .irq_vec_i (irq_vec),
      .int_o     (int_o)
   );

   status_readback u_readback (
      .dsp_clk         (dsp_clk),
      .wb_rst          (wb_rst),
      .slv_req_i       (rb_req),
      .slv_rsp_o       (rb_rsp),
      .status_i        (status_i),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .irq_vec_i       (irq_vec)
   );

endmodule

`default_nettype wire

/* sim/u2_ctrl_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Response checker
// Compares host responses and board outputs, reports per test
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module u2_ctrl_checker (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  u2_ctrl_pkg::bus_req_t    host_req_i,
   input  u2_ctrl_pkg::bus_rsp_t    host_rsp_i,
   input  u2_ctrl_pkg::board_ctrl_t board_i,
   input  u2_ctrl_pkg::led_t        leds_i,
   input  logic                     int_i,
   input  u2_ctrl_pkg::bus_dat_t    exp_dat_i,
   input  u2_ctrl_pkg::bus_dat_t    exp_mask_i,
   input  logic                     exp_err_i,
   input  logic                     exp_rel_i,
   input  logic                     out_chk_i,
   input  logic [13:0]              exp_board_i,
   input  u2_ctrl_pkg::led_t        exp_leds_i,
   input  logic                     exp_int_i,
   input  logic [2:0]               out_sel_i,
   input  logic                     test_end_i,
   input  logic [255:0]             test_name_i,
   input  logic                     run_end_i,
   output int                       err_total_o,
   output logic                     report_done_o
);
   import u2_ctrl_pkg::*;

   logic [13:0] board_bits;
   bit          rsp_due;
   bit          due_we;
   bit          due_err;
   bit          due_rel;
   bus_adr_t    due_adr;
   bus_dat_t    due_dat;
   bus_dat_t    due_mask;
   bus_dat_t    last_rd;
   int          test_checks;
   int          test_errs;
   int          checks_all;
   int          errors_all;
   int          tests_run;
   int          tests_failed;
   bit          report_done;

   assign board_bits    = board_i;
   assign err_total_o   = errors_all;
   assign report_done_o = report_done;

   task count_error;
      test_errs++;
      errors_all++;
   endtask

   // Response to the request seen on the previous edge
   task check_response;
      bus_dat_t want;
      if (host_rsp_i.ack && !rsp_due) begin
         $display("Ack arrived with no request outstanding");
         count_error();
      end
      if (rsp_due) begin
         test_checks++;
         checks_all++;
         want = due_rel ? last_rd + due_dat : due_dat;
         if (!host_rsp_i.ack) begin
            $display("No ack one cycle after the access to address 0x%04h", due_adr);
            count_error();
         end else begin
            if (host_rsp_i.err !== due_err) begin
               $display("Err flag was %0b at address 0x%04h, expected %0b",
                        host_rsp_i.err, due_adr, due_err);
               count_error();
            end
            if (((host_rsp_i.dat ^ want) & due_mask) !== '0) begin
               $display("ERROR host_rsp_o.dat: got 0x%08h expected 0x%08h mask 0x%08h",
                        host_rsp_i.dat, want, due_mask);
               count_error();
            end
            if (!due_we) begin
               last_rd = host_rsp_i.dat;
            end
         end
      end
   endtask

   task check_outputs;
      test_checks++;
      checks_all++;
      if (out_sel_i[0] && board_bits !== exp_board_i) begin
         $display("ERROR board_o: got 0x%04h expected 0x%04h", board_bits, exp_board_i);
         count_error();
      end
      if (out_sel_i[1] && leds_i !== exp_leds_i) begin
         $display("ERROR leds_o: got 0x%02h expected 0x%02h", leds_i, exp_leds_i);
         count_error();
      end
      if (out_sel_i[2] && int_i !== exp_int_i) begin
         $display("ERROR int_o: got 0x%0h expected 0x%0h", int_i, exp_int_i);
         count_error();
      end
   endtask

   always @(posedge dsp_clk) begin
      if (wb_rst) begin
         rsp_due = 1'b0;
      end else begin
         check_response();
         if (out_chk_i) begin
            check_outputs();
         end
         if (test_end_i) begin
            tests_run++;
            if (test_errs != 0) begin
               tests_failed++;
            end
            $display("%0s %0s: %0d checks, %0d errors",
                     (test_errs != 0) ? "FAIL" : "PASS", test_name_i,
                     test_checks, test_errs);
            test_checks = 0;
            test_errs   = 0;
         end
         if (run_end_i) begin
            $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                     tests_run, tests_failed, checks_all, errors_all);
            report_done = 1'b1;
         end
         // Capture this edge's request for next cycle
         rsp_due  = host_req_i.stb;
         due_we   = host_req_i.we;
         due_adr  = host_req_i.adr;
         due_dat  = exp_dat_i;
         due_mask = exp_mask_i;
         due_err  = exp_err_i;
         due_rel  = exp_rel_i;
      end
   end

endmodule

`default_nettype wire

/* sim/tb_u2_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Control-plane core testbench
// Replays the vector file on the host bus and side inputs
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ns

module tb_u2_ctrl;
   import u2_ctrl_pkg::*;

   localparam STIM_FILE = "sim/u2_ctrl_stimulus.txt";

   logic         dsp_clk;
   logic         wb_rst;
   bus_req_t     host_req;
   bus_rsp_t     host_rsp;
   logic         clk_status;
   logic         serdes_link_up;
   logic         phy_intn;
   logic [2:0]   ext_irq;
   bus_dat_t     status;
   logic         sim_mode;
   logic [3:0]   clock_divider;
   board_ctrl_t  board;
   led_t         leds;
   logic         dut_int;

   // Expected values handed to the checker with each operation
   bus_dat_t     exp_dat;
   bus_dat_t     exp_mask;
   logic         exp_err;
   logic         exp_rel;
   logic         out_chk;
   logic [13:0]  exp_board;
   led_t         exp_leds;
   logic         exp_int;
   logic [2:0]   out_sel;
   logic         test_end;
   logic         run_end;
   logic [255:0] test_name;
   int           err_total;
   logic         report_done;

   int           cycle_cnt;
   int           cycle_limit;
   bit           limit_set;
   int           tb_errors;

   u2_ctrl_top dut_i (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .host_req_i       (host_req),
      .host_rsp_o       (host_rsp),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (serdes_link_up),
      .phy_intn_i       (phy_intn),
      .ext_irq_i        (ext_irq),
      .status_i         (status),
      .sim_mode_i       (sim_mode),
      .clock_divider_i  (clock_divider),
      .board_o          (board),
      .leds_o           (leds),
      .int_o            (dut_int)
   );

   u2_ctrl_checker u_checker (
      .dsp_clk       (dsp_clk),
      .wb_rst        (wb_rst),
      .host_req_i    (host_req),
      .host_rsp_i    (host_rsp),
      .board_i       (board),
      .leds_i        (leds),
      .int_i         (dut_int),
      .exp_dat_i     (exp_dat),
      .exp_mask_i    (exp_mask),
      .exp_err_i     (exp_err),
      .exp_rel_i     (exp_rel),
      .out_chk_i     (out_chk),
      .exp_board_i   (exp_board),
      .exp_leds_i    (exp_leds),
      .exp_int_i     (exp_int),
      .out_sel_i     (out_sel),
      .test_end_i    (test_end),
      .test_name_i   (test_name),
      .run_end_i     (run_end),
      .err_total_o   (err_total),
      .report_done_o (report_done)
   );

   always #4 dsp_clk = ~dsp_clk;

   // Run limit from the vector file length
   always @(posedge dsp_clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (limit_set && cycle_cnt >= cycle_limit) begin
         $display("Run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   // Step to 1 ns after the next rising edge, all pulses low
   task automatic next_cycle;
      @(posedge dsp_clk);
      #1;
      host_req = '0;
      out_chk  = 1'b0;
      test_end = 1'b0;
      run_end  = 1'b0;
   endtask

   task automatic close_test;
      next_cycle();
      test_end = 1'b1;
      next_cycle();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Vector file, counted first, then executed

   task automatic process_file(input bit execute, output int cycles, output bit ok);
      int            fd;
      int            code;
      int            n;
      bit            stop;
      bit            test_open;
      logic [7:0]    op;
      logic [255:0]  name_v;
      logic [1023:0] skip_v;
      logic [31:0]   a, b, c, d, e, f, g;
      cycles    = 0;
      stop      = 1'b0;
      test_open = 1'b0;
      fd        = $fopen(STIM_FILE, "r");
      ok        = (fd != 0);
      stop      = !ok;
      while (!stop) begin
         code = $fscanf(fd, " %c", op);
         if (code != 1) begin
            stop = 1'b1;
         end else begin
            case (op)
               "#": code = $fgets(skip_v, fd);
               "T": begin
                  code = $fscanf(fd, "%s", name_v);
                  cycles += 2;
                  if (execute && test_open) begin
                     close_test();
                  end
                  if (execute) begin
                     test_name = name_v;
                  end
                  test_open = 1'b1;
               end
               "W", "R", "D": begin
                  code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                  cycles += 1;
                  if (execute) begin
                     next_cycle();
                     host_req.stb = 1'b1;
                     host_req.we  = (op == "W");
                     host_req.adr = a[15:0];
                     host_req.dat = b;
                     exp_dat      = c;
                     exp_mask     = d;
                     exp_rel      = (op == "D");
                     // Slave field 3 has no slave behind it
                     exp_err      = (a[7:6] == 2'b11);
                  end
               end
               "C": begin
                  code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                  cycles += 1;
                  if (execute) begin
                     next_cycle();
                     out_chk   = 1'b1;
                     exp_board = a[13:0];
                     exp_leds  = b[7:0];
                     exp_int   = c[0];
                     out_sel   = d[2:0];
                  end
               end
               "S": begin
                  code = $fscanf(fd, "%h %h %h %h %h %h %h", a, b, c, d, e, f, g);
                  cycles += 1;
                  if (execute) begin
                     next_cycle();
                     clk_status     = a[0];
                     serdes_link_up = b[0];
                     phy_intn       = c[0];
                     ext_irq        = d[2:0];
                     status         = e;
                     sim_mode       = f[0];
                     clock_divider  = g[3:0];
                  end
               end
               "I": begin
                  code = $fscanf(fd, "%d", n);
                  cycles += n;
                  if (execute) begin
                     repeat (n) next_cycle();
                  end
               end
               default: begin
                  if (execute) begin
                     $display("Stimulus file has an unknown line type '%c'", op);
                     tb_errors++;
                  end
                  stop = 1'b1;
               end
            endcase
         end
      end
      if (ok) begin
         $fclose(fd);
      end
      if (execute && test_open) begin
         close_test();
      end
   endtask

   initial begin
      int total;
      bit ok;
      dsp_clk        = 1'b0;
      wb_rst         = 1'b1;
      host_req       = '0;
      clk_status     = 1'b0;
      serdes_link_up = 1'b0;
      phy_intn       = 1'b1;
      ext_irq        = '0;
      status         = '0;
      sim_mode       = 1'b0;
      clock_divider  = '0;
      exp_dat        = '0;
      exp_mask       = '0;
      exp_err        = 1'b0;
      exp_rel        = 1'b0;
      out_chk        = 1'b0;
      exp_board      = '0;
      exp_leds       = '0;
      exp_int        = 1'b0;
      out_sel        = '0;
      test_end       = 1'b0;
      run_end        = 1'b0;
      test_name      = '0;
      cycle_cnt      = 0;
      cycle_limit    = 0;
      limit_set      = 1'b0;
      tb_errors      = 0;
      process_file(1'b0, total, ok);
      if (!ok) begin
         $display("Stimulus file %0s could not be opened", STIM_FILE);
         $display("TEST FAILED");
         $finish;
      end else begin
         cycle_limit = 2 * total + 100;
         limit_set   = 1'b1;
         repeat (8) @(posedge dsp_clk);
         #1;
         wb_rst = 1'b0;
         process_file(1'b1, total, ok);
         next_cycle();
         run_end = 1'b1;
         next_cycle();
         wait (report_done);
         if (err_total == 0 && tb_errors == 0) begin
            $display("TEST PASSED");
         end else begin
            $display("TEST FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

/* sim/u2_ctrl_stimulus.txt */
# T name | W/R/D adr data expect mask (D expect is delta from last read) | I cycles
# S clk_status link phy_intn ext_irq status sim_mode clkdiv | C board leds int select
T reset_board
C 0001 00 0 7
W 00 0000001F 00000000 FFFFFFFF
C 3E01 00 0 1
W 04 0000000A 00000000 FFFFFFFF
C 3F41 00 0 1
W 08 00000005 00000000 FFFFFFFF
C 3F4B 00 0 1
W 10 00000001 00000000 FFFFFFFF
C 3F4A 00 0 1
W 00 0000000A 00000000 FFFFFFFF
W 10 00000000 00000000 FFFFFFFF
C 154B 00 0 7
T led_mux
W 0C 000000F0 00000000 FFFFFFFF
C 0 F0 0 2
S 1 0 1 0 00000000 0 0
W 20 00000003 00000000 FFFFFFFF
C 0 F2 0 2
S 1 1 1 0 00000000 0 0
C 0 F3 0 2
S 0 0 1 0 00000000 0 0
C 0 F0 0 2
W 0C 0000000F 00000000 FFFFFFFF
C 0 0C 0 2
W 20 00000000 00000000 FFFFFFFF
C 0 0F 0 2
T readback
S 1 0 0 5 00001234 1 9
R 84 0 80000009 FFFFFFFF
R 88 0 00001234 FFFFFFFF
R 8C 0 0000000C FFFFFFFF
R 90 0 000000AC FFFFFFFF
S 0 0 1 0 00000000 0 0
R 8C 0 FFFFFFFF FFFFFFFF
R 84 0 00000000 FFFFFFFF
R 80 0 00000000 00000000
D 80 0 00000001 FFFFFFFF
W 84 12345678 00000000 FFFFFFFF
R 84 0 00000000 FFFFFFFF
T timer_irq
W 44 000000FF 00000000 FFFFFFFF
R 44 0 00000000 000000FF
W 30 00000014 00000000 FFFFFFFF
I 30
R 44 0 00000001 000000FF
W 34 0000000A 00000000 FFFFFFFF
I 50
R 44 0 00000003 000000FF
W 34 00000000 00000000 FFFFFFFF
I 2
W 44 00000003 00000000 FFFFFFFF
R 44 0 00000000 000000FF
S 0 0 0 4 00000000 0 0
W 40 000000FF 00000000 FFFFFFFF
I 2
C 0 00 1 4
R 48 0 00000007 FFFFFFFF
R 44 0 00000084 000000FF
W 40 00000004 00000000 FFFFFFFF
R 40 0 00000004 FFFFFFFF
R 48 0 00000002 FFFFFFFF
W 40 00000000 00000000 FFFFFFFF
I 2
C 0 00 0 4
R 48 0 FFFFFFFF FFFFFFFF
S 0 0 1 0 00000000 0 0
W 44 000000FF 00000000 FFFFFFFF
R 44 0 00000000 000000FF
T unmapped
R C0 0 00000000 FFFFFFFF
R FC 0 00000000 FFFFFFFF
W C4 DEADBEEF 00000000 FFFFFFFF
R 4C 0 00000000 FFFFFFFF

/* u2_ctrl_top.f */
+incdir+src
src/u2_ctrl_pkg.sv
src/bus_decoder.sv
src/settings_regs.sv
src/sys_timer.sv
src/int_ctrl.sv
src/status_readback.sv
src/u2_ctrl_top.sv
sim/u2_ctrl_checker.sv
sim/tb_u2_ctrl.sv
